// File: common/strand_core_settings.svh
`ifndef STRAND_CORE_SETTINGS_SVH
`define STRAND_CORE_SETTINGS_SVH

////////////////////
// Core geometry
////////////////////

// Number of hardware strands in the barrel.
`define STRAND_COUNT 4

`define REG_COUNT 16 // Scalar registers per strand.

// Start PC of strand n is n times this, in words.
`define STRAND_START_STRIDE 256

`endif

// File: common/strand_core_pkg.sv
`include "strand_core_settings.svh"

package strand_core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [$clog2(`STRAND_COUNT)-1:0] strand_id_t;
	typedef logic [$clog2(`REG_COUNT)-1:0] reg_index_t;
	typedef logic [`STRAND_COUNT-1:0] strand_mask_t; // One bit per strand.

	////////////////////
	// Instruction set
	////////////////////

	// Instruction word layout:
	//   [31:28] opcode
	//   [27:24] dest
	//   [23:20] src1
	//   [19:16] src2
	//   [15:0]  immediate
	typedef enum logic [3:0]
	{
		OP_NOP   = 4'h0,
		OP_ADD   = 4'h1,
		OP_SUB   = 4'h2,
		OP_AND   = 4'h3,
		OP_OR    = 4'h4,
		OP_XOR   = 4'h5,
		OP_SHL   = 4'h6, // Shift amount is src2[4:0].
		OP_SHR   = 4'h7,
		OP_ADDI  = 4'h8,
		OP_LUI   = 4'h9, // Immediate into bits 31:16.
		OP_BEQZ  = 4'ha,
		OP_BNEZ  = 4'hb,
		OP_JMP   = 4'hc,
		OP_STORE = 4'hd, // mem[src1 + imm] = src2.
		OP_HALT  = 4'he
	} opcode_t;

	typedef enum logic [1:0]
	{
		STRAND_IDLE,
		STRAND_RUN,
		STRAND_HALTED
	} strand_state_t;

endpackage

// File: hdl/scalar_register_file.sv
`timescale 1ns/10ps
`include "strand_core_settings.svh"

module scalar_register_file
	import strand_core_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic [5:0] sel1_i,
	input  logic [5:0] sel2_i,
	output word_t      value1_o,
	output word_t      value2_o,
	input  logic       write_en_i,
	input  logic [5:0] write_sel_i,
	input  word_t      write_value_i
);

	word_t regs [`STRAND_COUNT * `REG_COUNT];

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < `STRAND_COUNT * `REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (write_en_i)
			regs[write_sel_i] <= write_value_i;

		// Same-cycle writes are seen only on the next read.
		value1_o <= regs[sel1_i];
		value2_o <= regs[sel2_i];
	end

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/10ps

module decode_stage
	import strand_core_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic       valid_i,
	input  strand_id_t strand_i,
	input  word_t      pc_i,
	input  word_t      idata_i,
	input  logic       flush_i,
	output logic [5:0] src1_sel_o,
	output logic [5:0] src2_sel_o,
	output logic       valid_o,
	output strand_id_t strand_o,
	output word_t      pc_o,
	output opcode_t    opcode_o,
	output reg_index_t dest_o,
	output reg_index_t src1_o,
	output reg_index_t src2_o,
	output word_t      immediate_o
);

	opcode_t opcode;
	word_t   immediate;

	assign opcode = opcode_t'(idata_i[31:28]);
	assign src1_sel_o = {strand_i, idata_i[23:20]};
	assign src2_sel_o = {strand_i, idata_i[19:16]};

	// LUI places the field high, everything else sign-extends.
	assign immediate = (opcode == OP_LUI) ? {idata_i[15:0], 16'h0000}
		: {{16{idata_i[15]}}, idata_i[15:0]};

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
			valid_o <= 1'b0;
		else
			valid_o <= valid_i && !flush_i;
		strand_o <= strand_i;
		pc_o <= pc_i;
		opcode_o <= opcode;
		dest_o <= idata_i[27:24];
		src1_o <= idata_i[23:20];
		src2_o <= idata_i[19:16];
		immediate_o <= immediate;
	end

endmodule

// File: hdl/strand_select/strand_select_stage.sv
`timescale 1ns/10ps
`include "strand_core_settings.svh"

module strand_select_stage
	import strand_core_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n_i,
	input  logic         start_i,
	input  strand_mask_t strand_enable_i,
	input  strand_mask_t rollback_i,
	input  word_t        rollback_pc_i,
	input  strand_mask_t halt_strand_i,
	input  logic         flush_i,
	output word_t        iaddress_o,
	output logic         iaccess_o,
	output logic         issue_valid_o,
	output strand_id_t   issue_strand_o,
	output word_t        issue_pc_o,
	output strand_mask_t strand_running_o
);

	strand_state_t state_q [`STRAND_COUNT];
	word_t         pc_q [`STRAND_COUNT];
	strand_id_t    last_q; // Round-robin pointer.
	strand_id_t    pick;
	logic          pick_valid;

	always_comb
	begin
		for (int n = 0; n < `STRAND_COUNT; n++)
			strand_running_o[n] = (state_q[n] == STRAND_RUN);
	end

	// Nearest running strand after the last issued one wins.
	always_comb
	begin
		strand_id_t cand;

		pick = last_q;
		pick_valid = 1'b0;
		for (int i = `STRAND_COUNT; i >= 1; i--)
		begin
			cand = strand_id_t'(int'(last_q) + i);
			if (strand_running_o[cand])
			begin
				pick = cand;
				pick_valid = 1'b1;
			end
		end
	end

	assign iaddress_o = pc_q[pick];
	assign iaccess_o = pick_valid;

	////////////////////
	// Strand state
	////////////////////

	always_ff @(posedge clk)
	begin
		for (int n = 0; n < `STRAND_COUNT; n++)
		begin
			if (!rst_n_i)
			begin
				state_q[n] <= STRAND_IDLE;
				pc_q[n] <= word_t'(n * `STRAND_START_STRIDE);
			end
			else if (start_i)
			begin
				state_q[n] <= strand_enable_i[n] ? STRAND_RUN : STRAND_IDLE;
				pc_q[n] <= word_t'(n * `STRAND_START_STRIDE);
			end
			else
			begin
				if (state_q[n] == STRAND_RUN && halt_strand_i[n])
					state_q[n] <= STRAND_HALTED;
				if (rollback_i[n])
					pc_q[n] <= rollback_pc_i; // Overrides the advance.
				else if (pick_valid && pick == strand_id_t'(n))
					pc_q[n] <= pc_q[n] + 32'd1;
			end
		end
	end

	// Issue record for the decode cycle.
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			last_q <= '0;
			issue_valid_o <= 1'b0;
		end
		else
		begin
			if (pick_valid)
				last_q <= pick;
			issue_valid_o <= pick_valid && !flush_i;
		end
		issue_strand_o <= pick;
		issue_pc_o <= pc_q[pick];
	end

endmodule

// File: hdl/execute/execute_stage.sv
`timescale 1ns/10ps

module execute_stage
	import strand_core_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic       valid_i,
	input  strand_id_t strand_i,
	input  word_t      pc_i,
	input  opcode_t    opcode_i,
	input  reg_index_t dest_i,
	input  reg_index_t src1_i,
	input  reg_index_t src2_i,
	input  word_t      immediate_i,
	input  word_t      value1_i,
	input  word_t      value2_i,
	input  logic       wb_valid_i,
	input  strand_id_t wb_strand_i,
	input  reg_index_t wb_dest_i,
	input  word_t      wb_value_i,
	input  logic       late_valid_i,
	input  strand_id_t late_strand_i,
	input  reg_index_t late_dest_i,
	input  word_t      late_value_i,
	output logic       redirect_o,
	output strand_id_t redirect_strand_o,
	output word_t      redirect_pc_o,
	output logic       redirect_halt_o,
	output logic       dwrite_o,
	output word_t      daddress_o,
	output word_t      ddata_o,
	output strand_id_t dstrand_o,
	output logic       wb_valid_o,
	output strand_id_t wb_strand_o,
	output reg_index_t wb_dest_o,
	output word_t      wb_value_o
);

	word_t operand1;
	word_t operand2;
	word_t result;
	logic  has_writeback;
	logic  taken;

	// Newest matching write wins over older ones.
	function automatic word_t bypass(reg_index_t src, word_t rf_value);
		if (wb_valid_i && wb_strand_i == strand_i && wb_dest_i == src)
			return wb_value_i;
		if (late_valid_i && late_strand_i == strand_i && late_dest_i == src)
			return late_value_i;
		return rf_value;
	endfunction

	assign operand1 = bypass(src1_i, value1_i);
	assign operand2 = bypass(src2_i, value2_i);

	////////////////////
	// ALU
	////////////////////

	always_comb
	begin
		result = '0;
		has_writeback = 1'b1;
		case (opcode_i)
			OP_ADD:  result = operand1 + operand2;
			OP_SUB:  result = operand1 - operand2;
			OP_AND:  result = operand1 & operand2;
			OP_OR:   result = operand1 | operand2;
			OP_XOR:  result = operand1 ^ operand2;
			OP_SHL:  result = operand1 << operand2[4:0];
			OP_SHR:  result = operand1 >> operand2[4:0];
			OP_ADDI: result = operand1 + immediate_i;
			OP_LUI:  result = immediate_i;
			default: has_writeback = 1'b0; // Branches, stores, NOP, HALT.
		endcase
	end

	always_comb
	begin
		case (opcode_i)
			OP_BEQZ: taken = (operand1 == '0);
			OP_BNEZ: taken = (operand1 != '0);
			OP_JMP:  taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign redirect_halt_o = valid_i && opcode_i == OP_HALT;
	assign redirect_o = (valid_i && taken) || redirect_halt_o;
	assign redirect_strand_o = strand_i;
	assign redirect_pc_o = pc_i + 32'd1 + immediate_i;

	////////////////////
	// Stage registers
	////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			dwrite_o <= 1'b0;
			wb_valid_o <= 1'b0;
		end
		else
		begin
			dwrite_o <= valid_i && opcode_i == OP_STORE; // One-cycle pulse.
			wb_valid_o <= valid_i && has_writeback;
		end
		daddress_o <= operand1 + immediate_i;
		ddata_o <= operand2;
		dstrand_o <= strand_i;
		wb_strand_o <= strand_i;
		wb_dest_o <= dest_i;
		wb_value_o <= result;
	end

endmodule

// File: hdl/writeback_stage.sv
`timescale 1ns/10ps

module writeback_stage
	import strand_core_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic       valid_i,
	input  strand_id_t strand_i,
	input  reg_index_t dest_i,
	input  word_t      value_i,
	output logic       write_en_o,
	output logic [5:0] write_sel_o,
	output logic       late_valid_o,
	output strand_id_t late_strand_o,
	output reg_index_t late_dest_o,
	output word_t      late_value_o
);

	assign write_en_o = valid_i;
	assign write_sel_o = {strand_i, dest_i};

	// Held one more cycle, the read that overlapped this write missed it.
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
			late_valid_o <= 1'b0;
		else
			late_valid_o <= valid_i;
		late_strand_o <= strand_i;
		late_dest_o <= dest_i;
		late_value_o <= value_i;
	end

endmodule

// File: hdl/rollback_controller.sv
`timescale 1ns/10ps

module rollback_controller
	import strand_core_pkg::*;
(
	input  logic         redirect_i,
	input  strand_id_t   redirect_strand_i,
	input  word_t        redirect_pc_i,
	input  logic         redirect_halt_i,
	input  logic         ds_valid_i,
	input  strand_id_t   ds_strand_i,
	input  logic         ss_valid_i,
	input  strand_id_t   ss_strand_i,
	output logic         flush_ss_o,
	output logic         flush_ds_o,
	output strand_mask_t rollback_o,
	output word_t        rollback_pc_o,
	output strand_mask_t halt_strand_o
);

	always_comb
	begin
		rollback_o = '0;
		halt_strand_o = '0;
		if (redirect_i)
		begin
			if (redirect_halt_i)
				halt_strand_o[redirect_strand_i] = 1'b1;
			else
				rollback_o[redirect_strand_i] = 1'b1;
		end
	end

	assign rollback_pc_o = redirect_pc_i;

	// Only younger work of the redirecting strand is dropped.
	assign flush_ds_o = redirect_i && ds_valid_i && ds_strand_i == redirect_strand_i;
	assign flush_ss_o = redirect_i && ss_valid_i && ss_strand_i == redirect_strand_i;

endmodule

// File: hdl/strand_core.sv
`timescale 1ns/10ps
`include "strand_core_settings.svh"

module strand_core
	import strand_core_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n_i,
	input  logic         start_i,
	input  strand_mask_t strand_enable_i,
	output word_t        iaddress_o,
	output logic         iaccess_o,
	input  word_t        idata_i,
	output logic         dwrite_o,
	output word_t        daddress_o,
	output word_t        ddata_o,
	output strand_id_t   dstrand_o,
	output logic         halt_o
);

	logic         ss_valid;
	strand_id_t   ss_strand;
	word_t        ss_pc;
	strand_id_t   fetch_strand;
	strand_mask_t strand_running;
	logic [5:0]   src1_sel;
	logic [5:0]   src2_sel;
	logic         ds_valid;
	strand_id_t   ds_strand;
	word_t        ds_pc;
	opcode_t      ds_opcode;
	reg_index_t   ds_dest;
	reg_index_t   ds_src1;
	reg_index_t   ds_src2;
	word_t        ds_immediate;
	word_t        rf_value1;
	word_t        rf_value2;
	logic         ex_wb_valid;
	strand_id_t   ex_wb_strand;
	reg_index_t   ex_wb_dest;
	word_t        ex_wb_value;
	logic         rf_write_en;
	logic [5:0]   rf_write_sel;
	logic         late_valid;
	strand_id_t   late_strand;
	reg_index_t   late_dest;
	word_t        late_value;
	logic         redirect;
	strand_id_t   redirect_strand;
	word_t        redirect_pc;
	logic         redirect_halt;
	logic         flush_ss;
	logic         flush_ds;
	strand_mask_t rollback;
	word_t        rollback_pc;
	strand_mask_t halt_strand;
	logic         run_active;

	// Strand of the fetch in flight, from its start range.
	assign fetch_strand = strand_id_t'(iaddress_o / `STRAND_START_STRIDE);

	strand_select_stage u_ss (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.start_i(start_i),
		.strand_enable_i(strand_enable_i),
		.rollback_i(rollback),
		.rollback_pc_i(rollback_pc),
		.halt_strand_i(halt_strand),
		.flush_i(flush_ss),
		.iaddress_o(iaddress_o),
		.iaccess_o(iaccess_o),
		.issue_valid_o(ss_valid),
		.issue_strand_o(ss_strand),
		.issue_pc_o(ss_pc),
		.strand_running_o(strand_running)
	);

	decode_stage u_ds (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.valid_i(ss_valid),
		.strand_i(ss_strand),
		.pc_i(ss_pc),
		.idata_i(idata_i),
		.flush_i(flush_ds),
		.src1_sel_o(src1_sel),
		.src2_sel_o(src2_sel),
		.valid_o(ds_valid),
		.strand_o(ds_strand),
		.pc_o(ds_pc),
		.opcode_o(ds_opcode),
		.dest_o(ds_dest),
		.src1_o(ds_src1),
		.src2_o(ds_src2),
		.immediate_o(ds_immediate)
	);

	scalar_register_file u_srf (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.sel1_i(src1_sel),
		.sel2_i(src2_sel),
		.value1_o(rf_value1),
		.value2_o(rf_value2),
		.write_en_i(rf_write_en),
		.write_sel_i(rf_write_sel),
		.write_value_i(ex_wb_value)
	);

	execute_stage u_ex (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.valid_i(ds_valid),
		.strand_i(ds_strand),
		.pc_i(ds_pc),
		.opcode_i(ds_opcode),
		.dest_i(ds_dest),
		.src1_i(ds_src1),
		.src2_i(ds_src2),
		.immediate_i(ds_immediate),
		.value1_i(rf_value1),
		.value2_i(rf_value2),
		.wb_valid_i(ex_wb_valid),
		.wb_strand_i(ex_wb_strand),
		.wb_dest_i(ex_wb_dest),
		.wb_value_i(ex_wb_value),
		.late_valid_i(late_valid),
		.late_strand_i(late_strand),
		.late_dest_i(late_dest),
		.late_value_i(late_value),
		.redirect_o(redirect),
		.redirect_strand_o(redirect_strand),
		.redirect_pc_o(redirect_pc),
		.redirect_halt_o(redirect_halt),
		.dwrite_o(dwrite_o),
		.daddress_o(daddress_o),
		.ddata_o(ddata_o),
		.dstrand_o(dstrand_o),
		.wb_valid_o(ex_wb_valid),
		.wb_strand_o(ex_wb_strand),
		.wb_dest_o(ex_wb_dest),
		.wb_value_o(ex_wb_value)
	);

	writeback_stage u_wb (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.valid_i(ex_wb_valid),
		.strand_i(ex_wb_strand),
		.dest_i(ex_wb_dest),
		.value_i(ex_wb_value),
		.write_en_o(rf_write_en),
		.write_sel_o(rf_write_sel),
		.late_valid_o(late_valid),
		.late_strand_o(late_strand),
		.late_dest_o(late_dest),
		.late_value_o(late_value)
	);

	rollback_controller u_rbc (
		.redirect_i(redirect),
		.redirect_strand_i(redirect_strand),
		.redirect_pc_i(redirect_pc),
		.redirect_halt_i(redirect_halt),
		.ds_valid_i(ss_valid),
		.ds_strand_i(ss_strand),
		.ss_valid_i(iaccess_o),
		.ss_strand_i(fetch_strand),
		.flush_ss_o(flush_ss),
		.flush_ds_o(flush_ds),
		.rollback_o(rollback),
		.rollback_pc_o(rollback_pc),
		.halt_strand_o(halt_strand)
	);

	// Halt once every strand has stopped and the back end has drained.
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			run_active <= 1'b0;
			halt_o <= 1'b0;
		end
		else if (start_i)
		begin
			run_active <= 1'b1;
			halt_o <= 1'b0;
		end
		else if (run_active && strand_running == '0 && !ds_valid && !ex_wb_valid)
		begin
			run_active <= 1'b0;
			halt_o <= 1'b1; // Held until the next start.
		end
	end

endmodule

// File: testbench/strand_core_tb.sv
`timescale 1ns/10ps
`include "strand_core_settings.svh"

module strand_core_tb
	import strand_core_pkg::*;
;

	localparam int ROM_WORDS = `STRAND_COUNT * `STRAND_START_STRIDE;
	localparam int EXP_DEPTH = 1024;
	localparam int TEST_COUNT = 5;
	localparam int MODEL_STEP_LIMIT = 4000;
	localparam int RANDOM_SEED = 9347;
	localparam reg_index_t COND_REG = 4'd12;
	localparam reg_index_t LOOP_REG = 4'd14;
	localparam reg_index_t ZERO_REG = 4'd15; // Never written, stays zero.

	typedef logic [$clog2(ROM_WORDS)-1:0] rom_index_t;
	typedef logic [$clog2(EXP_DEPTH)-1:0] exp_index_t;

	logic         clk = 1'b0;
	logic         rst_n_i;
	logic         start_i;
	strand_mask_t strand_enable_i;
	word_t        iaddress_o;
	logic         iaccess_o;
	word_t        idata_i = '0;
	logic         dwrite_o;
	word_t        daddress_o;
	word_t        ddata_o;
	strand_id_t   dstrand_o;
	logic         halt_o;

	word_t        rom [ROM_WORDS];
	rom_index_t   fetch_index = '0;
	word_t        exp_addr [`STRAND_COUNT][EXP_DEPTH];
	word_t        exp_data [`STRAND_COUNT][EXP_DEPTH];
	int           exp_head [`STRAND_COUNT];
	int           exp_tail [`STRAND_COUNT];
	int           gen_pc;
	int           error_count = 0;
	int           cycle_count = 0;
	int           cycle_limit = TEST_COUNT * 100;
	string        test_name = "none";
	strand_mask_t cur_enable = '0;

	strand_core u_dut (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.start_i(start_i),
		.strand_enable_i(strand_enable_i),
		.iaddress_o(iaddress_o),
		.iaccess_o(iaccess_o),
		.idata_i(idata_i),
		.dwrite_o(dwrite_o),
		.daddress_o(daddress_o),
		.ddata_o(ddata_o),
		.dstrand_o(dstrand_o),
		.halt_o(halt_o)
	);

	always #5 clk = ~clk;

	// Word for last cycle's fetch, held through the decode cycle.
	always @(negedge clk)
	begin
		idata_i = rom[fetch_index];
		fetch_index = rom_index_t'(iaddress_o);
	end

	////////////////////
	// Program generator
	////////////////////

	function automatic word_t encode(opcode_t op, reg_index_t d, reg_index_t a, reg_index_t b,
		logic [15:0] imm);
		return {op, d, a, b, imm};
	endfunction

	function automatic reg_index_t data_reg();
		return reg_index_t'($urandom % 8);
	endfunction

	task automatic put(input word_t w);
		rom[rom_index_t'(gen_pc)] = w;
		gen_pc++;
	endtask

	task automatic put_alu(input reg_index_t d);
		put(encode(opcode_t'(4'(1 + $urandom % 9)), d, data_reg(), data_reg(), 16'($urandom)));
	endtask

	task automatic put_store(input reg_index_t b);
		put(encode(OP_STORE, 4'd0, ($urandom % 2) ? ZERO_REG : data_reg(), b, 16'($urandom)));
	endtask

	// Condition is set just before, so the branch reads a bypassed value.
	task automatic put_branch();
		int skip;

		skip = 1 + $urandom % 3;
		put(encode(OP_ADDI, COND_REG, ZERO_REG, 4'd0, 16'($urandom % 2)));
		case ($urandom % 3)
			0: put(encode(OP_BEQZ, 4'd0, COND_REG, 4'd0, 16'(skip)));
			1: put(encode(OP_BNEZ, 4'd0, COND_REG, 4'd0, 16'(skip)));
			default: put(encode(OP_JMP, 4'd0, 4'd0, 4'd0, 16'(skip)));
		endcase
		for (int i = 0; i < skip; i++)
		begin
			if ($urandom % 2)
				put_store(data_reg()); // Never seen when taken.
			else
				put_alu(data_reg());
		end
	endtask

	task automatic put_loop();
		int body_start;
		int body_len;

		put(encode(OP_ADDI, LOOP_REG, ZERO_REG, 4'd0, 16'(1 + $urandom % 4)));
		body_start = gen_pc;
		body_len = 1 + $urandom % 3;
		for (int i = 0; i < body_len; i++)
			put_alu(data_reg());
		put_store(data_reg());
		put_store(LOOP_REG);
		put(encode(OP_ADDI, LOOP_REG, LOOP_REG, 4'd0, 16'hffff)); // Count down.
		put(encode(OP_BNEZ, 4'd0, LOOP_REG, 4'd0, 16'(body_start - gen_pc - 1)));
	endtask

	// Mode 0 is ALU with stores, 1 is mixed, 2 is branch heavy.
	task automatic gen_program(input int s, input int mode);
		int items;
		int last;
		int pick;
		reg_index_t d;

		gen_pc = s * `STRAND_START_STRIDE;
		last = gen_pc + `STRAND_START_STRIDE - 16;
		for (int r = 0; r < 8; r++)
		begin
			put(encode(OP_LUI, reg_index_t'(r), ZERO_REG, 4'd0, 16'($urandom)));
			put(encode(OP_ADDI, reg_index_t'(r), reg_index_t'(r), 4'd0, 16'($urandom)));
		end
		items = (mode == 0) ? 48 : 10 + $urandom % 30;
		for (int i = 0; i < items && gen_pc < last; i++)
		begin
			pick = $urandom % 10;
			d = data_reg();
			if (mode == 0)
			begin
				put_alu(d);
				if ($urandom % 2)
					put_alu(data_reg()); // Store then hits the late copy.
				put_store(d);
			end
			else if (pick < ((mode == 1) ? 5 : 2))
				put_alu(d);
			else if (pick < ((mode == 1) ? 8 : 4))
				put_store(d);
			else if (pick < ((mode == 1) ? 9 : 7))
				put_branch();
			else
				put_loop();
		end
		put(encode(OP_HALT, 4'd0, 4'd0, 4'd0, 16'h0000));
		put_store(data_reg()); // Flushed by the HALT.
		put_store(data_reg());
	endtask

	////////////////////
	// Reference model
	////////////////////

	function automatic int model_strand(input strand_id_t s);
		word_t      regs [`REG_COUNT];
		word_t      pc;
		word_t      instr;
		word_t      imm;
		opcode_t    op;
		reg_index_t d;
		reg_index_t a;
		reg_index_t b;
		int         steps;
		logic       done;

		for (int r = 0; r < `REG_COUNT; r++)
			regs[r] = '0;
		pc = word_t'(s) * `STRAND_START_STRIDE;
		steps = 0;
		done = 1'b0;
		while (!done && steps < MODEL_STEP_LIMIT)
		begin
			instr = rom[rom_index_t'(pc)];
			op = opcode_t'(instr[31:28]);
			d = instr[27:24];
			a = instr[23:20];
			b = instr[19:16];
			imm = {{16{instr[15]}}, instr[15:0]};
			steps++;
			pc = pc + 32'd1;
			case (op)
				OP_ADD:  regs[d] = regs[a] + regs[b];
				OP_SUB:  regs[d] = regs[a] - regs[b];
				OP_AND:  regs[d] = regs[a] & regs[b];
				OP_OR:   regs[d] = regs[a] | regs[b];
				OP_XOR:  regs[d] = regs[a] ^ regs[b];
				OP_SHL:  regs[d] = regs[a] << regs[b][4:0];
				OP_SHR:  regs[d] = regs[a] >> regs[b][4:0];
				OP_ADDI: regs[d] = regs[a] + imm;
				OP_LUI:  regs[d] = {instr[15:0], 16'h0000};
				OP_BEQZ: if (regs[a] == '0) pc = pc + imm;
				OP_BNEZ: if (regs[a] != '0) pc = pc + imm;
				OP_JMP:  pc = pc + imm;
				OP_STORE:
				begin
					if (exp_tail[s] < EXP_DEPTH)
					begin
						exp_addr[s][exp_index_t'(exp_tail[s])] = regs[a] + imm;
						exp_data[s][exp_index_t'(exp_tail[s])] = regs[b];
						exp_tail[s]++;
					end
				end
				OP_HALT: done = 1'b1;
				default: ;
			endcase
		end
		if (!done)
		begin
			$display("%s: program of strand %0d never reaches HALT", test_name, s);
			error_count++;
		end
		return steps;
	endfunction

	////////////////////
	// Checks
	////////////////////

	task automatic check_store(input strand_id_t strand, input word_t exp_address,
		input word_t exp_value, input word_t act_address, input word_t act_value);
		if (act_address !== exp_address)
		begin
			$display("FAILED %s: strand %0d store address expected %h actual %h",
				test_name, strand, exp_address, act_address);
			error_count++;
		end
		if (act_value !== exp_value)
		begin
			$display("FAILED %s: strand %0d store data expected %h actual %h",
				test_name, strand, exp_value, act_value);
			error_count++;
		end
	endtask

	task automatic check_level(input string what, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("FAILED %s: %s expected %b actual %b", test_name, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_halt();
		for (int n = 0; n < `STRAND_COUNT; n++)
		begin
			if (exp_head[n] != exp_tail[n])
			begin
				$display("FAILED %s: strand %0d stores pending at halt expected 0 actual %0d",
					test_name, n, exp_tail[n] - exp_head[n]);
				error_count++;
			end
		end
	endtask

	// Store monitor.
	always @(negedge clk)
	begin
		if (dwrite_o === 1'b1)
		begin
			if (exp_head[dstrand_o] >= exp_tail[dstrand_o])
			begin
				$display("%s: strand %0d stored %h to %h with no store left in its program",
					test_name, dstrand_o, ddata_o, daddress_o);
				error_count++;
			end
			else
			begin
				check_store(dstrand_o, exp_addr[dstrand_o][exp_index_t'(exp_head[dstrand_o])],
					exp_data[dstrand_o][exp_index_t'(exp_head[dstrand_o])], daddress_o, ddata_o);
				exp_head[dstrand_o]++;
			end
		end
	end

	// Fetches stay inside enabled strand ranges.
	always @(negedge clk)
	begin
		int owner;

		if (iaccess_o === 1'b1)
		begin
			owner = int'(iaddress_o / `STRAND_START_STRIDE);
			if (owner >= `STRAND_COUNT || !cur_enable[strand_id_t'(owner)])
			begin
				$display("%s: fetch from %h lies outside the enabled strands", test_name, iaddress_o);
				error_count++;
			end
		end
	end

	////////////////////
	// Test sequence
	////////////////////

	task automatic run_test(input string name, input strand_mask_t enable, input int mode);
		int steps;

		test_name = name;
		cur_enable = enable;
		for (int i = 0; i < ROM_WORDS; i++)
			rom[rom_index_t'(i)] = {OP_NOP, 28'(i)};
		for (int n = 0; n < `STRAND_COUNT; n++)
		begin
			exp_head[n] = 0;
			exp_tail[n] = 0;
			if (enable[n])
			begin
				gen_program(n, mode);
				steps = model_strand(strand_id_t'(n));
				cycle_limit += 8 * steps;
			end
		end
		rst_n_i = 1'b0;
		repeat (5) @(negedge clk);
		rst_n_i = 1'b1;
		repeat (3)
		begin
			@(negedge clk);
			check_level("iaccess_o before start", 1'b0, iaccess_o);
			check_level("dwrite_o before start", 1'b0, dwrite_o);
			check_level("halt_o before start", 1'b0, halt_o);
		end
		strand_enable_i = enable;
		start_i = 1'b1;
		@(negedge clk);
		start_i = 1'b0;
		while (halt_o !== 1'b1)
			@(negedge clk);
		check_halt();
		repeat (10)
		begin
			@(negedge clk);
			check_level("halt_o held", 1'b1, halt_o);
			check_level("dwrite_o after halt", 1'b0, dwrite_o);
			check_level("iaccess_o after halt", 1'b0, iaccess_o);
		end
	endtask

	initial
	begin
		void'($urandom(RANDOM_SEED));
		rst_n_i = 1'b0;
		start_i = 1'b0;
		strand_enable_i = '0;
		run_test("alu_bypass", 4'b0001, 0);
		run_test("four_strand_random", 4'b1111, 1);
		run_test("branch_loop", 4'b0100, 2);
		run_test("branch_loop_multi", 4'b1111, 2);
		run_test("partial_enable", 4'b1010, 1);
		$display("errors: %0d", error_count);
		if (error_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// Limit grows as each program is modeled.
	initial
	begin
		while (cycle_count < cycle_limit)
		begin
			@(posedge clk);
			cycle_count++;
		end
		error_count++;
		$display("timeout in %s after %0d cycles without the run ending", test_name, cycle_count);
		$display("errors: %0d", error_count);
		$display("sim failed");
		$finish;
	end

endmodule

// File: strand_core.f
+incdir+common
common/strand_core_pkg.sv
hdl/scalar_register_file.sv
hdl/decode_stage.sv
hdl/strand_select/strand_select_stage.sv
hdl/execute/execute_stage.sv
hdl/writeback_stage.sv
hdl/rollback_controller.sv
hdl/strand_core.sv
testbench/strand_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall
TB_TOP    := strand_core_tb
RTL_TOP   := strand_core
FILELIST  := strand_core.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
